// ==== rv_cpu.f ====
source/rv_pkg.sv
source/rv_inst_mem.sv
source/rv_decoder.sv
source/rv_reg_file.sv
source/rv_alu.sv
source/rv_execute.sv
source/rv_cpu.sv
verification/rv_cpu_checker.sv
verification/rv_cpu_tb.sv

// ==== source/rv_alu.sv ====
// ----------------------------------------
// rv_alu: combinational integer ALU
// ----------------------------------------
`default_nettype none

module rv_alu (
    input  wire rv_pkg::alu_op_e i_op,
    input  wire rv_pkg::word_t   i_a,
    input  wire rv_pkg::word_t   i_b,
    output rv_pkg::word_t        o_result
);
    import rv_pkg::*;

    logic [$clog2(XLEN)-1:0] shamt;

    // low bits of b only, as in rv32i
    assign shamt = i_b[$clog2(XLEN)-1:0];

    always_comb begin
        case (i_op)
            ALU_ADD:    o_result = i_a + i_b;
            ALU_SUB:    o_result = i_a - i_b;
            ALU_AND:    o_result = i_a & i_b;
            ALU_OR:     o_result = i_a | i_b;
            ALU_XOR:    o_result = i_a ^ i_b;
            ALU_SLT:    o_result = word_t'($signed(i_a) < $signed(i_b));
            ALU_SLTU:   o_result = word_t'(i_a < i_b);
            ALU_SLL:    o_result = i_a << shamt;
            ALU_SRL:    o_result = i_a >> shamt;
            ALU_PASS_B: o_result = i_b;
            default:    o_result = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== source/rv_cpu.sv ====
// ----------------------------------------
// rv_cpu: five stage RV32I integer core with
// a program load port and an ecall result port
// ----------------------------------------
`default_nettype none

module rv_cpu (
    input  wire logic          i_clk,
    input  wire logic          i_rst_n,
    // program load, idle only
    input  wire logic          i_imem_valid,
    input  wire rv_pkg::pc_t   i_imem_addr,
    input  wire rv_pkg::word_t i_imem_data,
    output logic               o_imem_ready,
    // run control and ecall result
    input  wire logic          i_start,
    output logic               o_ecall_valid,
    output rv_pkg::word_t      o_ecall_data,
    input  wire logic          i_ecall_ready
);
    import rv_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_RUN,
        ST_DRAIN,
        ST_DONE
    } state_e;

    state_e    state;
    state_e    next_state;

    // fetch and decode register
    pc_t       pc;
    word_t     fetch_inst;
    logic      fetch_en;
    logic      br_pending;
    logic      dec_valid;
    pc_t       dec_pc;
    word_t     dec_inst;

    // decoder and register read
    reg_addr_t dec_rd;
    reg_addr_t dec_rs1;
    reg_addr_t dec_rs2;
    word_t     dec_imm;
    alu_op_e   dec_alu_op;
    logic      dec_use_imm;
    logic      dec_reg_write;
    logic      dec_branch;
    logic      dec_branch_ne;
    logic      dec_ecall;
    word_t     rf_rdata1;
    word_t     rf_rdata2;

    // issue register
    logic      iss_valid;
    pc_t       iss_pc;
    reg_addr_t iss_rd;
    reg_addr_t iss_rs1;
    reg_addr_t iss_rs2;
    word_t     iss_rs1_data;
    word_t     iss_rs2_data;
    word_t     iss_imm;
    alu_op_e   iss_alu_op;
    logic      iss_use_imm;
    logic      iss_reg_write;
    logic      iss_branch;
    logic      iss_branch_ne;
    logic      iss_ecall;

    // execute results
    logic      wb_we;
    reg_addr_t wb_rd;
    word_t     wb_data;
    logic      br_done;
    logic      br_taken;
    pc_t       br_target;
    logic      ecall_hit;
    word_t     ecall_value;

    // ----------------------------------------
    // run control
    // ----------------------------------------
    always_comb begin
        case (state)
            ST_IDLE:  next_state = i_start ? ST_RUN : ST_IDLE;
            ST_RUN:   next_state = dec_ecall ? ST_DRAIN : ST_RUN;
            ST_DRAIN: next_state = ecall_hit ? ST_DONE : ST_DRAIN;
            ST_DONE:  next_state = i_ecall_ready ? ST_IDLE : ST_DONE;
            default:  next_state = ST_IDLE;
        endcase
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state <= ST_IDLE;
        end else begin
            state <= next_state;
        end
    end

    assign o_imem_ready  = (state == ST_IDLE);
    assign o_ecall_valid = (state == ST_DONE);

    // held by the ecall port until acknowledged
    always_ff @(posedge i_clk) begin
        if (ecall_hit) begin
            o_ecall_data <= ecall_value;
        end
    end

    // ----------------------------------------
    // fetch
    // ----------------------------------------
    // bubbles while a branch is in flight or an ecall is seen
    assign fetch_en = (state == ST_RUN) && !dec_branch && !br_pending && !dec_ecall;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            pc         <= '0;
            br_pending <= 1'b0;
        end else if (state == ST_IDLE) begin
            pc         <= '0;
            br_pending <= 1'b0;
        end else if (br_done) begin
            pc         <= br_taken ? br_target : iss_pc + 1'b1;
            br_pending <= 1'b0;
        end else begin
            if (fetch_en) begin
                pc <= pc + 1'b1;
            end
            if (dec_branch) begin
                br_pending <= 1'b1;
            end
        end
    end

    rv_inst_mem i_inst_mem (
        .i_clk   (i_clk),
        .i_we    (i_imem_valid & o_imem_ready),
        .i_waddr (i_imem_addr),
        .i_wdata (i_imem_data),
        .i_raddr (pc),
        .o_rdata (fetch_inst)
    );

    // ----------------------------------------
    // decode and register read
    // ----------------------------------------
    rv_decoder i_decoder (
        .i_inst      (dec_inst),
        .i_valid     (dec_valid),
        .o_rd        (dec_rd),
        .o_rs1       (dec_rs1),
        .o_rs2       (dec_rs2),
        .o_imm       (dec_imm),
        .o_alu_op    (dec_alu_op),
        .o_use_imm   (dec_use_imm),
        .o_reg_write (dec_reg_write),
        .o_branch    (dec_branch),
        .o_branch_ne (dec_branch_ne),
        .o_ecall     (dec_ecall)
    );

    rv_reg_file i_reg_file (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .i_we     (wb_we),
        .i_waddr  (wb_rd),
        .i_wdata  (wb_data),
        .i_raddr1 (dec_rs1),
        .i_raddr2 (dec_rs2),
        .o_rdata1 (rf_rdata1),
        .o_rdata2 (rf_rdata2)
    );

    // stage valid flags
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            dec_valid <= 1'b0;
            iss_valid <= 1'b0;
        end else begin
            dec_valid <= fetch_en;
            iss_valid <= dec_valid;
        end
    end

    // decode and issue payload
    always_ff @(posedge i_clk) begin
        dec_pc        <= pc;
        dec_inst      <= fetch_inst;
        iss_pc        <= dec_pc;
        iss_rd        <= dec_rd;
        iss_rs1       <= dec_rs1;
        iss_rs2       <= dec_rs2;
        iss_rs1_data  <= rf_rdata1;
        iss_rs2_data  <= rf_rdata2;
        iss_imm       <= dec_imm;
        iss_alu_op    <= dec_alu_op;
        iss_use_imm   <= dec_use_imm;
        iss_reg_write <= dec_reg_write;
        iss_branch    <= dec_branch;
        iss_branch_ne <= dec_branch_ne;
        iss_ecall     <= dec_ecall;
    end

    // ----------------------------------------
    // execute and writeback
    // ----------------------------------------
    rv_execute i_execute (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_valid       (iss_valid),
        .i_pc          (iss_pc),
        .i_rd          (iss_rd),
        .i_rs1         (iss_rs1),
        .i_rs2         (iss_rs2),
        .i_rs1_data    (iss_rs1_data),
        .i_rs2_data    (iss_rs2_data),
        .i_imm         (iss_imm),
        .i_alu_op      (iss_alu_op),
        .i_use_imm     (iss_use_imm),
        .i_reg_write   (iss_reg_write),
        .i_branch      (iss_branch),
        .i_branch_ne   (iss_branch_ne),
        .i_ecall       (iss_ecall),
        .o_wb_we       (wb_we),
        .o_wb_rd       (wb_rd),
        .o_wb_data     (wb_data),
        .o_br_done     (br_done),
        .o_br_taken    (br_taken),
        .o_br_target   (br_target),
        .o_ecall_hit   (ecall_hit),
        .o_ecall_value (ecall_value)
    );

endmodule

`default_nettype wire

// ==== source/rv_decoder.sv ====
// ----------------------------------------
// rv_decoder: instruction word to register
// indices, immediate and control flags
// ----------------------------------------
`default_nettype none

module rv_decoder (
    input  wire rv_pkg::word_t  i_inst,
    input  wire logic           i_valid,
    output rv_pkg::reg_addr_t   o_rd,
    output rv_pkg::reg_addr_t   o_rs1,
    output rv_pkg::reg_addr_t   o_rs2,
    output rv_pkg::word_t       o_imm,
    output rv_pkg::alu_op_e     o_alu_op,
    output logic                o_use_imm,
    output logic                o_reg_write,
    output logic                o_branch,
    output logic                o_branch_ne,
    output logic                o_ecall
);
    import rv_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       funct7_b5;
    word_t      imm_i;
    word_t      imm_u;
    word_t      imm_b;
    alu_op_e    arith_op;

    assign opcode    = i_inst[6:0];
    assign funct3    = i_inst[14:12];
    assign funct7_b5 = i_inst[30];

    // sign extended immediates
    assign imm_i = {{20{i_inst[31]}}, i_inst[31:20]};
    assign imm_u = {i_inst[31:12], 12'b0};
    assign imm_b = {{20{i_inst[31]}}, i_inst[7], i_inst[30:25], i_inst[11:8], 1'b0};

    // shared by register and immediate forms
    always_comb begin
        case (funct3)
            3'b000:  arith_op = ALU_ADD;
            3'b001:  arith_op = ALU_SLL;
            3'b010:  arith_op = ALU_SLT;
            3'b011:  arith_op = ALU_SLTU;
            3'b100:  arith_op = ALU_XOR;
            3'b101:  arith_op = ALU_SRL;
            3'b110:  arith_op = ALU_OR;
            default: arith_op = ALU_AND;
        endcase
    end

    always_comb begin
        o_rd        = i_inst[11:7];
        o_rs1       = i_inst[19:15];
        o_rs2       = i_inst[24:20];
        o_imm       = imm_i;
        o_alu_op    = arith_op;
        o_use_imm   = 1'b0;
        o_reg_write = 1'b0;
        o_branch    = 1'b0;
        o_branch_ne = 1'b0;
        o_ecall     = 1'b0;
        // anything not matched below leaves a bubble
        if (i_valid) begin
            case (opcode)
                OPC_OP: begin
                    o_reg_write = 1'b1;
                    if (funct3 == 3'b000 && funct7_b5) begin
                        o_alu_op = ALU_SUB;
                    end
                end
                OPC_OP_IMM: begin
                    o_use_imm   = 1'b1;
                    o_reg_write = 1'b1;
                end
                OPC_LUI: begin
                    o_imm       = imm_u;
                    o_alu_op    = ALU_PASS_B;
                    o_use_imm   = 1'b1;
                    o_reg_write = 1'b1;
                end
                OPC_BRANCH: begin
                    // beq and bne only
                    o_imm       = imm_b;
                    o_branch    = (funct3[2:1] == 2'b00);
                    o_branch_ne = funct3[0];
                end
                OPC_SYSTEM: begin
                    // a0 comes through the normal read and forward path
                    o_rs1   = ECALL_REG;
                    o_ecall = (i_inst[31:7] == '0);
                end
                default: begin
                    o_reg_write = 1'b0;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== source/rv_execute.sv ====
// ----------------------------------------
// rv_execute: forwarding, ALU, branch
// resolution and the writeback register
// ----------------------------------------
`default_nettype none

module rv_execute (
    input  wire logic              i_clk,
    input  wire logic              i_rst_n,
    input  wire logic              i_valid,
    input  wire rv_pkg::pc_t       i_pc,
    input  wire rv_pkg::reg_addr_t i_rd,
    input  wire rv_pkg::reg_addr_t i_rs1,
    input  wire rv_pkg::reg_addr_t i_rs2,
    input  wire rv_pkg::word_t     i_rs1_data,
    input  wire rv_pkg::word_t     i_rs2_data,
    input  wire rv_pkg::word_t     i_imm,
    input  wire rv_pkg::alu_op_e   i_alu_op,
    input  wire logic              i_use_imm,
    input  wire logic              i_reg_write,
    input  wire logic              i_branch,
    input  wire logic              i_branch_ne,
    input  wire logic              i_ecall,
    output logic                   o_wb_we,
    output rv_pkg::reg_addr_t      o_wb_rd,
    output rv_pkg::word_t          o_wb_data,
    output logic                   o_br_done,
    output logic                   o_br_taken,
    output rv_pkg::pc_t            o_br_target,
    output logic                   o_ecall_hit,
    output rv_pkg::word_t          o_ecall_value
);
    import rv_pkg::*;

    logic  fwd_rs1;
    logic  fwd_rs2;
    word_t op_a;
    word_t rs2_val;
    word_t op_b;
    word_t alu_result;

    // result of the instruction one ahead
    assign fwd_rs1 = o_wb_we && (o_wb_rd != '0) && (o_wb_rd == i_rs1);
    assign fwd_rs2 = o_wb_we && (o_wb_rd != '0) && (o_wb_rd == i_rs2);

    assign op_a    = fwd_rs1 ? o_wb_data : i_rs1_data;
    assign rs2_val = fwd_rs2 ? o_wb_data : i_rs2_data;
    assign op_b    = i_use_imm ? i_imm : rs2_val;

    rv_alu i_alu (
        .i_op     (i_alu_op),
        .i_a      (op_a),
        .i_b      (op_b),
        .o_result (alu_result)
    );

    // beq / bne, target in words from the byte offset
    assign o_br_done   = i_valid & i_branch;
    assign o_br_taken  = i_branch_ne ? (op_a != rs2_val) : (op_a == rs2_val);
    assign o_br_target = i_pc + i_imm[PC_W+1:2];

    // a0 as forwarded
    assign o_ecall_hit   = i_valid & i_ecall;
    assign o_ecall_value = op_a;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_wb_we <= 1'b0;
        end else begin
            o_wb_we <= i_valid & i_reg_write;
        end
    end

    always_ff @(posedge i_clk) begin
        o_wb_rd   <= i_rd;
        o_wb_data <= alu_result;
    end

endmodule

`default_nettype wire

// ==== source/rv_inst_mem.sv ====
// ----------------------------------------
// rv_inst_mem: instruction RAM, written by
// the load port, read asynchronously by fetch
// ----------------------------------------
`default_nettype none

module rv_inst_mem (
    input  wire logic          i_clk,
    input  wire logic          i_we,
    input  wire rv_pkg::pc_t   i_waddr,
    input  wire rv_pkg::word_t i_wdata,
    input  wire rv_pkg::pc_t   i_raddr,
    output rv_pkg::word_t      o_rdata
);
    import rv_pkg::*;

    word_t mem [IMEM_DEPTH];

    // load beats only
    always_ff @(posedge i_clk) begin
        if (i_we) begin
            mem[i_waddr] <= i_wdata;
        end
    end

    // fetch sees the word in the same cycle
    assign o_rdata = mem[i_raddr];

endmodule

`default_nettype wire

// ==== source/rv_pkg.sv ====
// ----------------------------------------
// rv_pkg: widths, types and encodings
// shared by the rv_cpu integer pipeline
// ----------------------------------------
`default_nettype none

package rv_pkg;

    // data path
    localparam int XLEN = 32;
    typedef logic [XLEN-1:0] word_t;

    // register index
    localparam int REG_ADDR_W = 5;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    // instruction memory, pc counts words
    localparam int IMEM_DEPTH = 64;
    localparam int PC_W = $clog2(IMEM_DEPTH);
    typedef logic [PC_W-1:0] pc_t;

    // major opcodes of the kept instructions
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

    // alu operations
    typedef enum logic [3:0] {
        ALU_ADD    = 4'd0,
        ALU_SUB    = 4'd1,
        ALU_AND    = 4'd2,
        ALU_OR     = 4'd3,
        ALU_XOR    = 4'd4,
        ALU_SLT    = 4'd5,
        ALU_SLTU   = 4'd6,
        ALU_SLL    = 4'd7,
        ALU_SRL    = 4'd8,
        // operand b straight through, for lui
        ALU_PASS_B = 4'd9
    } alu_op_e;

    // ecall reports a0
    localparam reg_addr_t ECALL_REG = 5'd10;

endpackage

`default_nettype wire

// ==== source/rv_reg_file.sv ====
// ----------------------------------------
// rv_reg_file: 32 x 32 register file, x0
// tied to zero, write-first read bypass
// ----------------------------------------
`default_nettype none

module rv_reg_file (
    input  wire logic              i_clk,
    input  wire logic              i_rst_n,
    input  wire logic              i_we,
    input  wire rv_pkg::reg_addr_t i_waddr,
    input  wire rv_pkg::word_t     i_wdata,
    input  wire rv_pkg::reg_addr_t i_raddr1,
    input  wire rv_pkg::reg_addr_t i_raddr2,
    output rv_pkg::word_t          o_rdata1,
    output rv_pkg::word_t          o_rdata2
);
    import rv_pkg::*;

    // x1 .. x31
    word_t regs [1:2**REG_ADDR_W-1];

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int i = 1; i < 2**REG_ADDR_W; i++) begin
                regs[i] <= '0;
            end
        end else if (i_we && i_waddr != '0) begin
            regs[i_waddr] <= i_wdata;
        end
    end

    // same-cycle write wins, covers the instruction two ahead
    assign o_rdata1 = (i_raddr1 == '0) ? '0 :
                      (i_we && i_raddr1 == i_waddr) ? i_wdata : regs[i_raddr1];
    assign o_rdata2 = (i_raddr2 == '0) ? '0 :
                      (i_we && i_raddr2 == i_waddr) ? i_wdata : regs[i_raddr2];

endmodule

`default_nettype wire

// ==== verification/rv_cpu_checker.sv ====
// ----------------------------------------
// rv_cpu_checker: load and ecall handshake
// assertions, bound into rv_cpu
// ----------------------------------------
`default_nettype none

module rv_cpu_checker (
    input wire logic          i_clk,
    input wire logic          i_rst_n,
    input wire logic          i_start,
    input wire logic          i_imem_ready,
    input wire logic          i_ecall_valid,
    input wire rv_pkg::word_t i_ecall_data,
    input wire logic          i_ecall_ready
);

    // failed assertions, read by the testbench summary
    int assert_errors = 0;

    // result held until the consumer takes it
    a_ecall_stable: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        (i_ecall_valid && !i_ecall_ready) |=> (i_ecall_valid && $stable(i_ecall_data))
    ) else begin
        $error("ecall valid or data changed before ready");
        assert_errors++;
    end

    // no program load from start until the result is taken
    a_ready_idle: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        ((!i_imem_ready || i_start) && !(i_ecall_valid && i_ecall_ready)) |=> !i_imem_ready
    ) else begin
        $error("imem ready high while a program runs");
        assert_errors++;
    end

    // the acknowledge hands the port back to the loader
    a_ready_vs_valid: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        (i_ecall_valid && i_ecall_ready) |=> (i_imem_ready && !i_ecall_valid)
    ) else begin
        $error("ecall ack did not return the core to idle");
        assert_errors++;
    end

endmodule

bind rv_cpu rv_cpu_checker i_checker (
    .i_clk         (i_clk),
    .i_rst_n       (i_rst_n),
    .i_start       (i_start),
    .i_imem_ready  (o_imem_ready),
    .i_ecall_valid (o_ecall_valid),
    .i_ecall_data  (o_ecall_data),
    .i_ecall_ready (i_ecall_ready)
);

`default_nettype wire

// ==== verification/rv_cpu_tb.sv ====
// ----------------------------------------
// rv_cpu_tb: directed programs run through
// the load and ecall ports of rv_cpu
// ----------------------------------------
`default_nettype none

module rv_cpu_tb;
    import rv_pkg::*;

    // longest program in cycles, loop included, with margin
    localparam int LONGEST_PROG   = 400;
    localparam int NUM_TESTS      = 5;
    localparam int TIMEOUT_CYCLES = 10 * LONGEST_PROG * NUM_TESTS;

    // funct3 codes of the register and immediate ops
    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SRL  = 3'b101;
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    logic   i_clk;
    logic   i_rst_n;
    logic   i_imem_valid;
    pc_t    i_imem_addr;
    word_t  i_imem_data;
    logic   o_imem_ready;
    logic   i_start;
    logic   o_ecall_valid;
    word_t  o_ecall_data;
    logic   i_ecall_ready;

    integer seed;
    int     errors;
    int     checks;
    int     cycles;
    word_t  prog [$];

    rv_cpu i_dut (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_imem_valid  (i_imem_valid),
        .i_imem_addr   (i_imem_addr),
        .i_imem_data   (i_imem_data),
        .o_imem_ready  (o_imem_ready),
        .i_start       (i_start),
        .o_ecall_valid (o_ecall_valid),
        .o_ecall_data  (o_ecall_data),
        .i_ecall_ready (i_ecall_ready)
    );

    initial begin
        i_clk = 1'b0;
        forever #2 i_clk = ~i_clk;
    end

    initial begin
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge i_clk);
            cycles++;
        end
        $display("timeout: no ecall result after %0d cycles", cycles);
        $display("Some tests failed");
        $finish;
    end

    // ----------------------------------------
    // instruction encoding
    // ----------------------------------------
    function automatic word_t rr_word(input logic [2:0] f3, input reg_addr_t rd,
                                      input reg_addr_t rs1, input reg_addr_t rs2,
                                      input logic alt);
        return {1'b0, alt, 5'b0, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic word_t imm_word(input logic [2:0] f3, input reg_addr_t rd,
                                       input reg_addr_t rs1, input int imm);
        return {imm[11:0], rs1, f3, rd, OPC_OP_IMM};
    endfunction

    function automatic word_t lui_word(input reg_addr_t rd, input logic [19:0] upper);
        return {upper, rd, OPC_LUI};
    endfunction

    // byte offset, as in the ISA
    function automatic word_t branch_word(input logic ne, input reg_addr_t rs1,
                                          input reg_addr_t rs2, input int off);
        logic [12:0] o;
        o = off[12:0];
        return {o[12], o[10:5], rs2, rs1, 2'b00, ne, o[4:1], o[11], OPC_BRANCH};
    endfunction

    function automatic word_t ecall_word();
        return {25'b0, OPC_SYSTEM};
    endfunction

    // lui plus addi, upper part rounded for the signed low part
    task automatic const_to_reg(input reg_addr_t rd, input word_t value);
        word_t upper;
        upper = value + 32'h0000_0800;
        prog.push_back(lui_word(rd, upper[31:12]));
        prog.push_back(imm_word(F3_ADD, rd, rd, int'(value[11:0])));
    endtask

    // ----------------------------------------
    // port handling and compares
    // ----------------------------------------
    task automatic check_word(input string what, input word_t got, input word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error at %0t: %s got %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_bit(input string what, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error at %0t: %s got %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic load_program();
        for (int i = 0; i < prog.size(); i++) begin
            @(posedge i_clk);
            i_imem_valid <= 1'b1;
            i_imem_addr  <= pc_t'(i);
            i_imem_data  <= prog[i];
            // the edge after ready is seen takes the beat
            @(negedge i_clk);
            while (!o_imem_ready) begin
                @(negedge i_clk);
            end
        end
        @(posedge i_clk);
        i_imem_valid <= 1'b0;
    endtask

    task automatic run_program(input int hold, output word_t result);
        @(posedge i_clk);
        i_start <= 1'b1;
        @(posedge i_clk);
        i_start <= 1'b0;
        @(negedge i_clk);
        while (!o_ecall_valid) begin
            @(negedge i_clk);
        end
        result = o_ecall_data;
        // consumer not ready yet
        repeat (hold) begin
            @(negedge i_clk);
            check_bit("ecall valid while held", o_ecall_valid, 1'b1);
            check_word("ecall data while held", o_ecall_data, result);
        end
        @(posedge i_clk);
        i_ecall_ready <= 1'b1;
        @(posedge i_clk);
        i_ecall_ready <= 1'b0;
        @(negedge i_clk);
        check_bit("imem ready after ack", o_imem_ready, 1'b1);
        check_bit("ecall valid after ack", o_ecall_valid, 1'b0);
    endtask

    // ----------------------------------------
    // directed tests
    // ----------------------------------------
    task automatic reset_values();
        @(negedge i_clk);
        check_bit("ecall valid after reset", o_ecall_valid, 1'b0);
        check_bit("imem ready after reset", o_imem_ready, 1'b1);
    endtask

    task automatic forward_chain();
        word_t a;
        word_t b;
        word_t c;
        word_t t5;
        word_t t6;
        word_t exp;
        word_t got;
        a = $random(seed);
        b = $random(seed);
        c = $random(seed);
        prog.delete();
        const_to_reg(5'd1, a);
        const_to_reg(5'd2, b);
        const_to_reg(5'd3, c);
        prog.push_back(rr_word(F3_ADD, 5'd10, 5'd1, 5'd2, 1'b0));
        prog.push_back(rr_word(F3_ADD, 5'd10, 5'd10, 5'd3, 1'b1));
        prog.push_back(rr_word(F3_XOR, 5'd10, 5'd10, 5'd1, 1'b0));
        prog.push_back(rr_word(F3_OR, 5'd10, 5'd10, 5'd2, 1'b0));
        prog.push_back(rr_word(F3_AND, 5'd10, 5'd10, 5'd3, 1'b0));
        prog.push_back(rr_word(F3_SLL, 5'd10, 5'd10, 5'd2, 1'b0));
        prog.push_back(rr_word(F3_SRL, 5'd5, 5'd10, 5'd3, 1'b0));
        prog.push_back(rr_word(F3_XOR, 5'd6, 5'd5, 5'd1, 1'b0));
        // x6 from the writeback register, x5 through the bypass
        prog.push_back(rr_word(F3_ADD, 5'd10, 5'd6, 5'd5, 1'b0));
        prog.push_back(rr_word(F3_SLTU, 5'd7, 5'd6, 5'd5, 1'b0));
        prog.push_back(rr_word(F3_ADD, 5'd10, 5'd10, 5'd7, 1'b0));
        prog.push_back(ecall_word());
        exp = a + b;
        exp = exp - c;
        exp = exp ^ a;
        exp = exp | b;
        exp = exp & c;
        exp = exp << b[4:0];
        t5  = exp >> c[4:0];
        t6  = t5 ^ a;
        exp = t6 + t5;
        exp = exp + ((t6 < t5) ? 32'd1 : 32'd0);
        load_program();
        run_program(0, got);
        check_word("dependent chain a0", got, exp);
    endtask

    task automatic immediate_ops();
        word_t a;
        word_t t2;
        word_t t4;
        word_t flags;
        word_t exp;
        word_t got;
        a = $random(seed);
        a = a | 32'h8000_0000;
        prog.delete();
        const_to_reg(5'd1, a);
        prog.push_back(imm_word(F3_ADD, 5'd2, 5'd1, -5));
        prog.push_back(imm_word(F3_XOR, 5'd3, 5'd2, -1));
        prog.push_back(imm_word(F3_AND, 5'd4, 5'd3, -16));
        prog.push_back(imm_word(F3_OR, 5'd4, 5'd4, 32'h5a5));
        // signed versus unsigned on a negative value
        prog.push_back(imm_word(F3_SLT, 5'd5, 5'd1, 1));
        prog.push_back(imm_word(F3_SLTU, 5'd6, 5'd1, 1));
        prog.push_back(rr_word(F3_SLT, 5'd7, 5'd1, 5'd0, 1'b0));
        prog.push_back(rr_word(F3_SLTU, 5'd8, 5'd1, 5'd0, 1'b0));
        prog.push_back(imm_word(F3_SLTU, 5'd9, 5'd2, -1));
        prog.push_back(imm_word(F3_SLL, 5'd11, 5'd4, 3));
        prog.push_back(imm_word(F3_SRL, 5'd12, 5'd1, 7));
        prog.push_back(imm_word(F3_SLL, 5'd6, 5'd6, 1));
        prog.push_back(imm_word(F3_SLL, 5'd7, 5'd7, 2));
        prog.push_back(imm_word(F3_SLL, 5'd8, 5'd8, 3));
        prog.push_back(imm_word(F3_SLL, 5'd9, 5'd9, 4));
        prog.push_back(rr_word(F3_OR, 5'd5, 5'd5, 5'd6, 1'b0));
        prog.push_back(rr_word(F3_OR, 5'd5, 5'd5, 5'd7, 1'b0));
        prog.push_back(rr_word(F3_OR, 5'd5, 5'd5, 5'd8, 1'b0));
        prog.push_back(rr_word(F3_OR, 5'd5, 5'd5, 5'd9, 1'b0));
        prog.push_back(rr_word(F3_XOR, 5'd10, 5'd11, 5'd12, 1'b0));
        prog.push_back(rr_word(F3_XOR, 5'd10, 5'd10, 5'd5, 1'b0));
        prog.push_back(ecall_word());
        t2 = a + 32'hffff_fffb;
        t4 = ((t2 ^ 32'hffff_ffff) & 32'hffff_fff0) | 32'h0000_05a5;
        flags    = '0;
        flags[0] = ($signed(a) < $signed(32'sd1));
        flags[1] = (a < 32'd1);
        flags[2] = ($signed(a) < $signed(32'sd0));
        flags[3] = (a < 32'd0);
        flags[4] = (t2 < 32'hffff_ffff);
        exp = (t4 << 3) ^ (a >> 7) ^ flags;
        load_program();
        run_program(0, got);
        check_word("immediate ops a0", got, exp);
    endtask

    task automatic branch_loop();
        int    n;
        word_t exp;
        word_t got;
        n = 3 + ($unsigned($random(seed)) % 8);
        prog.delete();
        prog.push_back(imm_word(F3_ADD, 5'd1, 5'd0, n));
        prog.push_back(imm_word(F3_ADD, 5'd10, 5'd0, 0));
        prog.push_back(rr_word(F3_ADD, 5'd10, 5'd10, 5'd1, 1'b0));
        prog.push_back(imm_word(F3_ADD, 5'd1, 5'd1, -1));
        prog.push_back(branch_word(1'b1, 5'd1, 5'd0, -8));
        // jump over the instruction that would spoil a0
        prog.push_back(branch_word(1'b0, 5'd0, 5'd0, 8));
        prog.push_back(imm_word(F3_ADD, 5'd10, 5'd10, 32'h7ff));
        prog.push_back(ecall_word());
        exp = '0;
        for (int k = n; k > 0; k--) begin
            exp = exp + word_t'(k);
        end
        load_program();
        run_program(0, got);
        check_word("countdown sum a0", got, exp);
    endtask

    task automatic ecall_backpressure();
        word_t v;
        word_t got;
        v = $random(seed);
        prog.delete();
        const_to_reg(5'd20, v);
        prog.push_back(imm_word(F3_ADD, 5'd10, 5'd20, 0));
        prog.push_back(ecall_word());
        load_program();
        run_program(6, got);
        check_word("first program a0", got, v);
        // x20 survives, x0 writes are dropped
        prog.delete();
        prog.push_back(imm_word(F3_ADD, 5'd0, 5'd0, 32'h123));
        prog.push_back(rr_word(F3_ADD, 5'd0, 5'd20, 5'd20, 1'b0));
        prog.push_back(rr_word(F3_ADD, 5'd10, 5'd0, 5'd20, 1'b0));
        prog.push_back(rr_word(F3_ADD, 5'd10, 5'd10, 5'd0, 1'b0));
        prog.push_back(ecall_word());
        load_program();
        run_program(2, got);
        check_word("second program a0", got, v);
    endtask

    initial begin
        seed          = 32'he093;
        errors        = 0;
        checks        = 0;
        i_rst_n       = 1'b0;
        i_imem_valid  = 1'b0;
        i_imem_addr   = '0;
        i_imem_data   = '0;
        i_start       = 1'b0;
        i_ecall_ready = 1'b0;
        repeat (4) @(posedge i_clk);
        i_rst_n <= 1'b1;
        reset_values();
        forward_chain();
        immediate_ops();
        branch_loop();
        ecall_backpressure();
        $display("checks: %0d, errors: %0d, assertion failures: %0d",
                 checks, errors, i_dut.i_checker.assert_errors);
        if (errors == 0 && i_dut.i_checker.assert_errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
